//--- design/gpio_pkg.sv
// GPIO peripheral shared definitions
// widths of the board pins and bus, the Wishbone request bundle
// and the state encoding of the NMI debounce machine

`default_nettype none

package gpio_pkg;

  localparam int LED_W = 14; // board LEDs driven by the register block
  localparam int SW_W  = 8;  // slide switches
  localparam int PB_W  = 4;  // push-buttons, only bit 0 has a function
  localparam int WB_DW = 16; // Wishbone data bus width

  // one Wishbone request as seen by the slave
  typedef struct packed {
    logic             adr; // register select, 0 switches, 1 leds
    logic [WB_DW-1:0] dat; // write data
    logic [1:0]       sel; // byte lanes
    logic             we;  // write enable
    logic             stb; // strobe
    logic             cyc; // bus cycle
  } gpio_wb_req_t;

  // debounce machine states
  typedef enum logic {
    IDLE = 1'b0, // following the button
    HOLD = 1'b1  // ignoring the button until the hold window ends
  } nmi_state_t;

endpackage

`default_nettype wire

//--- design/gpio_tick_timer.sv
// GPIO tick timer
// divides the bus clock into a one-cycle tick every TICK_DIV cycles,
// giving the debounce machine a time base of its own

`default_nettype none

module gpio_tick_timer #(
  parameter int TICK_DIV = 16 // clock cycles per tick
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  output logic tick_o
);

  // counter wide enough for TICK_DIV-1, at least one bit
  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] div_cnt; // cycles left until the next tick
  logic             cnt_zero;

  assign cnt_zero = (div_cnt == '0); // terminal count reached

  // down-counter, reloads on zero
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      div_cnt <= RELOAD; // first tick TICK_DIV cycles after reset
    end
    else if (cnt_zero)
    begin
      div_cnt <= RELOAD;
    end
    else
    begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // registered pulse, one cycle per period
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      tick_o <= 1'b0;
    else
      tick_o <= cnt_zero;
  end

  // tick is a single-cycle pulse unless the divider is bypassed
  a_tick_single: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    ((TICK_DIV > 1) && tick_o) |=> !tick_o
  ) else $error("tick_o high on two consecutive cycles");

endmodule

`default_nettype wire

//--- design/nmi_debounce_fsm.sv
// NMI push-button debouncer
// synchronizes the active-low button into the clock domain and copies
// its pressed level to the NMI output, then ignores the button for
// HOLD_TICKS ticks so contact bounce cannot toggle the NMI

`default_nettype none

module nmi_debounce_fsm
  import gpio_pkg::*;
#(
  parameter int HOLD_TICKS = 7 // ticks ignored after each change
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic pb_n_i, // raw button pin, low when pressed
  input  logic tick_i, // one-cycle time base pulse
  output logic nmi_o
);

  localparam int HCNT_W = $clog2(HOLD_TICKS + 1); // holds 0..HOLD_TICKS

  logic              pb_meta;    // first synchronizer stage
  logic              pb_sync;    // second synchronizer stage
  logic              pressed;    // button level, high when pressed
  nmi_state_t        state;
  logic [HCNT_W-1:0] hold_cnt;   // ticks seen in HOLD
  logic [HCNT_W-1:0] hold_next;
  logic              hold_done;

  // two-flop synchronizer, resets to the released level
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      pb_meta <= 1'b1;
      pb_sync <= 1'b1;
    end
    else
    begin
      pb_meta <= pb_n_i;
      pb_sync <= pb_meta;
    end
  end

  assign pressed   = ~pb_sync;               // active-low pin
  assign hold_next = hold_cnt + 1'b1;
  assign hold_done = (hold_next == HCNT_W'(HOLD_TICKS)); // last tick of window

  // state machine, nmi level and hold counter
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      state    <= IDLE;
      nmi_o    <= 1'b0;
      hold_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (pressed != nmi_o) // button moved, take it and start the hold
          begin
            nmi_o    <= pressed;
            hold_cnt <= '0;
            state    <= HOLD;
          end
        end
        HOLD:
        begin
          if (tick_i)
          begin
            hold_cnt <= hold_next; // count the window in ticks
            if (hold_done)
              state <= IDLE;       // window over, follow the button again
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // nmi only moves on a decision taken in IDLE
  a_nmi_from_idle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !$stable(nmi_o) |-> ($past(state) == IDLE)
  ) else $error("nmi_o changed while the fsm was in %s", state.name());

  // counter stays inside the hold window
  a_hold_bound: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    hold_cnt <= HCNT_W'(HOLD_TICKS)
  ) else $error("hold counter passed HOLD_TICKS");

endmodule

`default_nettype wire

//--- design/gpio_wb_regs.sv
// GPIO Wishbone register block
// address 0 reads the synchronized switches, address 1 reads and
// writes the LED register with byte lanes, ack without wait states

`default_nettype none

module gpio_wb_regs
  import gpio_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  gpio_wb_req_t     wb_req_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,

  input  logic [SW_W-1:0]  sw_i,
  output logic [LED_W-1:0] leds_o
);

  localparam int LO_W = 8;          // width of the low byte lane
  localparam int HI_W = LED_W - LO_W; // LED bits living in the high lane

  logic            op;       // active bus cycle
  logic            led_wr;   // write to the LED register
  logic [SW_W-1:0] sw_meta;  // first switch synchronizer stage
  logic [SW_W-1:0] sw_sync;  // switches in the clock domain

  // bus decode
  assign op       = wb_req_i.cyc & wb_req_i.stb;
  assign wb_ack_o = op;                              // no wait states
  assign led_wr   = op & wb_req_i.we & wb_req_i.adr; // address 1 only

  // two-flop synchronizer for the slide switches
  always_ff @(posedge wb_clk_i)
  begin
    sw_meta <= sw_i;
    sw_sync <= sw_meta;
  end

  // LED register, low lane
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      leds_o[LO_W-1:0] <= '0;
    else if (led_wr && wb_req_i.sel[0])
      leds_o[LO_W-1:0] <= wb_req_i.dat[LO_W-1:0];
  end

  // LED register, high lane holds bits 13 to 8
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      leds_o[LED_W-1:LO_W] <= '0;
    else if (led_wr && wb_req_i.sel[1])
      leds_o[LED_W-1:LO_W] <= wb_req_i.dat[LO_W +: HI_W];
  end

  // read mux, both sources zero-extended to the bus width
  always_comb
  begin
    if (wb_req_i.adr)
      wb_dat_o = {{(WB_DW - LED_W){1'b0}}, leds_o};
    else
      wb_dat_o = {{(WB_DW - SW_W){1'b0}}, sw_sync};
  end

  // ack only answers an active strobe
  a_ack_needs_cycle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("wb_ack_o high without cyc and stb");

endmodule

`default_nettype wire

//--- design/gpio_top.sv
// GPIO peripheral top level
// Wishbone register block for LEDs and switches, plus the tick timer
// and debounce machine that turn push-button 0 into an NMI level

`default_nettype none

module gpio_top
  import gpio_pkg::*;
#(
  parameter int TICK_DIV   = 16, // clock cycles per debounce tick
  parameter int HOLD_TICKS = 7   // ticks the button is ignored after a change
) (
  // Wishbone slave
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  input  logic [1:0]       wb_sel_i,
  input  logic             wb_we_i,
  input  logic             wb_stb_i,
  input  logic             wb_cyc_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,

  // board pins
  input  logic [SW_W-1:0]  sw_i,
  input  logic [PB_W-1:0]  pb_i,   // buttons 3 to 1 have no function
  output logic [LED_W-1:0] leds_o,
  output logic             nmi_o
);

  gpio_wb_req_t wb_req; // bus pins bundled for the register block
  logic         tick;   // debounce time base

  assign wb_req = '{
    adr: wb_adr_i,
    dat: wb_dat_i,
    sel: wb_sel_i,
    we:  wb_we_i,
    stb: wb_stb_i,
    cyc: wb_cyc_i
  };

  // switch and LED registers
  gpio_wb_regs u_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (wb_req),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .sw_i     (sw_i),
    .leds_o   (leds_o)
  );

  // clock divider
  gpio_tick_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_timer (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .tick_o   (tick)
  );

  // push-button 0 to NMI
  nmi_debounce_fsm #(
    .HOLD_TICKS (HOLD_TICKS)
  ) u_debounce (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .pb_n_i   (pb_i[0]),
    .tick_i   (tick),
    .nmi_o    (nmi_o)
  );

endmodule

`default_nettype wire

//--- verif/gpio_tb.sv
// GPIO peripheral testbench
// replays the vector file against gpio_top: Wishbone reads and writes,
// switch and button pins, NMI press, release and random contact bounce

`default_nettype none

module gpio_tb
  import gpio_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    TICK_DIV   = 4;                            // short ticks for a fast run
  localparam int    HOLD_TICKS = 7;
  localparam int    HOLD_WAIT  = HOLD_TICKS * TICK_DIV + 4;    // full hold window plus margin
  localparam int    NMI_LIMIT  = 16;                           // cycles allowed for nmi to follow
  localparam int    BOUNCE_MIN = 4;
  localparam int    BOUNCE_MAX = (HOLD_TICKS - 1) * TICK_DIV - 4; // stays inside shortest window
  localparam string VEC_FILE   = "verif/gpio_vectors.txt";

  logic             wb_clk_i;
  logic             wb_rst_i;
  logic             wb_adr_i;
  logic [WB_DW-1:0] wb_dat_i;
  logic [1:0]       wb_sel_i;
  logic             wb_we_i;
  logic             wb_stb_i;
  logic             wb_cyc_i;
  logic [WB_DW-1:0] wb_dat_o;
  logic             wb_ack_o;
  logic [SW_W-1:0]  sw_i;
  logic [PB_W-1:0]  pb_i;
  logic [LED_W-1:0] leds_o;
  logic             nmi_o;

  int               fd;        // vector file handle
  int               op_count;  // operations replayed
  logic [8*128-1:0] line_buf;  // rest of a comment line

  gpio_top #(
    .TICK_DIV   (TICK_DIV),
    .HOLD_TICKS (HOLD_TICKS)
  ) u_dut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .sw_i     (sw_i),
    .pb_i     (pb_i),
    .leds_o   (leds_o),
    .nmi_o    (nmi_o)
  );

  initial
  begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i; // 10 ns period
  end

  // single exit for every failure
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic need_fields(input int got, input int want);
    if (got != want)
      abort_run($sformatf("vector line %0d has %0d fields instead of %0d", op_count, got, want));
  endtask

  task automatic idle_bus();
    wb_adr_i = 1'b0;
    wb_dat_i = '0;
    wb_sel_i = 2'b00;
    wb_we_i  = 1'b0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  // one access, sampled mid-cycle, released after the edge
  task automatic bus_access(input logic cyc, input logic we, input logic adr,
                            input logic [1:0] sel, input logic [15:0] dat,
                            output logic [15:0] rdat, output logic ack);
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_we_i  = we;
    wb_stb_i = 1'b1;
    wb_cyc_i = cyc;
    @(negedge wb_clk_i);
    rdat = wb_dat_o;
    ack  = wb_ack_o;
    @(posedge wb_clk_i); // write edge
    #1;
    idle_bus();
  endtask

  task automatic wait_hold_window();
    repeat (HOLD_WAIT) @(posedge wb_clk_i);
    #1;
  endtask

  // waits for nmi to reach a level, then lets the hold window run out
  task automatic wait_nmi(input logic exp, input logic hold);
    int cnt;
    cnt = 0;
    @(negedge wb_clk_i);
    while (nmi_o !== exp && cnt < NMI_LIMIT)
    begin
      @(negedge wb_clk_i);
      cnt++;
    end
    if (nmi_o !== exp)
      abort_run($sformatf("timeout: nmi_o did not reach %0b within %0d cycles", exp, NMI_LIMIT));
    @(posedge wb_clk_i);
    #1;
    if (hold)
      wait_hold_window();
  endtask

  // press, then random toggling inside the hold window, then a final pin level
  task automatic bounce_button(input logic final_pin, input logic exp_nmi);
    int len;
    len = BOUNCE_MIN + int'($urandom % (BOUNCE_MAX - BOUNCE_MIN + 1));
    pb_i[0] = 1'b0;
    wait_nmi(1'b1, 1'b0);  // rise found, fsm now holding
    for (int i = 0; i < len; i++)
    begin
      pb_i[0] = 1'($urandom % 2); // bounce
      @(negedge wb_clk_i);
      check_value("nmi_o during bounce", 16'(nmi_o), 16'h0001);
      @(posedge wb_clk_i);
      #1;
    end
    pb_i[0] = final_pin;
    wait_hold_window();
    @(negedge wb_clk_i);
    check_value("nmi_o after bounce", 16'(nmi_o), 16'(exp_nmi));
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic run_op(input logic [7:0] op);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [15:0] rdat;
    logic        ack;
    int          n;
    case (op)
      "#": n = $fgets(line_buf, fd); // comment line
      "W":
      begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        need_fields(n, 3);
        bus_access(1'b1, 1'b1, a[0], b[1:0], c, rdat, ack);
        check_value("wb_ack_o on write", 16'(ack), 16'h0001);
      end
      "R":
      begin
        n = $fscanf(fd, "%h %h", a, b);
        need_fields(n, 2);
        bus_access(1'b1, 1'b0, a[0], 2'b11, 16'h0000, rdat, ack);
        check_value("wb_ack_o on read", 16'(ack), 16'h0001);
        check_value("wb_dat_o", rdat, b);
      end
      "I":
      begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        need_fields(n, 3);
        bus_access(1'b0, 1'b1, a[0], b[1:0], c, rdat, ack); // cyc low, stb high
        check_value("wb_ack_o with cyc low", 16'(ack), 16'h0000);
      end
      "S":
      begin
        n = $fscanf(fd, "%h", a);
        need_fields(n, 1);
        sw_i = a[SW_W-1:0];
        repeat (3) @(posedge wb_clk_i); // past the synchronizer
        #1;
      end
      "P":
      begin
        n = $fscanf(fd, "%h", a);
        need_fields(n, 1);
        pb_i[0] = a[0];
      end
      "B":
      begin
        n = $fscanf(fd, "%h %h", a, b);
        need_fields(n, 2);
        bounce_button(a[0], b[0]);
      end
      "N":
      begin
        n = $fscanf(fd, "%h", a);
        need_fields(n, 1);
        wait_nmi(a[0], 1'b1);
      end
      "L":
      begin
        n = $fscanf(fd, "%h", a);
        need_fields(n, 1);
        @(negedge wb_clk_i);
        check_value("leds_o", 16'(leds_o), a);
        @(posedge wb_clk_i);
        #1;
      end
      default: abort_run($sformatf("unknown operation '%c' in the vector file", op));
    endcase
  endtask

  initial
  begin
    int          seed;
    int          code;
    logic [7:0]  op;
    logic        reading;
    seed = 86;
    void'($urandom(seed)); // one seed for the whole run
    idle_bus();
    sw_i     = '0;
    pb_i     = '1;         // buttons released
    wb_rst_i = 1'b1;
    op_count = 0;
    repeat (5) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
      abort_run("could not open the vector file");
    reading = 1'b1;
    while (reading)
    begin
      code = $fscanf(fd, " %c", op);
      if (code != 1)
        reading = 1'b0;  // end of file
      else
      begin
        op_count++;
        run_op(op);
      end
    end
    $fclose(fd);
    $display("replayed %0d vector lines", op_count);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/gpio_vectors.txt
# W adr sel data | R adr exp_data | I adr sel data (cyc low) | S switches
# P pin | B final_pin exp_nmi | N exp_nmi | L exp_leds, all hex
# reset state
L 0000
N 0
R 1 0000
# full write masked to 14 bits
W 1 3 ffff
R 1 3fff
L 3fff
W 1 3 1234
R 1 1234
# high lane only keeps bits 7 to 0
W 1 2 ab55
R 1 2b34
L 2b34
# low lane only
W 1 1 00c3
R 1 2bc3
# write to the switch address leaves the leds alone
W 0 3 0f0f
L 2bc3
# switches
S a5
R 0 00a5
S 3c
R 0 003c
# nmi press and release
P 0
N 1
P 1
N 0
# bounce with the button left pressed
B 0 1
P 1
N 0
B 0 1
P 1
N 0
# bus idle
I 1 3 0000
L 2bc3
R 1 2bc3

//--- vlog.f
design/gpio_pkg.sv
design/gpio_tick_timer.sv
design/nmi_debounce_fsm.sv
design/gpio_wb_regs.sv
design/gpio_top.sv
verif/gpio_tb.sv
